//--- rtl/ieu_pkg.sv
`default_nettype none
// Shared widths, vector types and select encodings of the execution stage.
// Operation selects are one-hot, so at most one position may be set at a time.

package ieu_pkg;

   // Widths fixed by the instruction set
   localparam int unsigned DATA_W = 32;
   localparam int unsigned PC_W = DATA_W - 2;   // Word-aligned instruction address
   localparam int unsigned REG_AW = 5;

   typedef logic [DATA_W-1:0] word_t;
   typedef logic [PC_W-1:0] pc_t;
   typedef logic [REG_AW-1:0] reg_addr_t;

   // Arithmetic select, one-hot
   localparam int unsigned ARITH_OPW = 3;
   localparam int unsigned ARITH_ADD = 0;
   localparam int unsigned ARITH_SUB = 1;
   localparam int unsigned ARITH_CMP = 2;   // Updates the condition flag only

   typedef logic [ARITH_OPW-1:0] arith_opc_t;

   // Logic and shift select, one-hot
   localparam int unsigned LOGIC_OPW = 6;
   localparam int unsigned LOGIC_AND = 0;
   localparam int unsigned LOGIC_OR = 1;
   localparam int unsigned LOGIC_XOR = 2;
   localparam int unsigned LOGIC_SLL = 3;
   localparam int unsigned LOGIC_SRL = 4;
   localparam int unsigned LOGIC_SRA = 5;

   typedef logic [LOGIC_OPW-1:0] logic_opc_t;

   // Access size on the data bus
   typedef enum logic [1:0] {
      SIZE_BYTE = 2'd0,
      SIZE_HALF = 2'd1,
      SIZE_WORD = 2'd2
   } mem_size_t;

   // Load/store FSM states
   typedef enum logic [1:0] {
      LSU_IDLE = 2'd0,
      LSU_REQ = 2'd1,   // Request held on the bus
      LSU_RSP = 2'd2    // Load waits for read data
   } lsu_state_t;

endpackage

`default_nettype wire

//--- rtl/ieu_arith.sv
`timescale 1ns/1ns
`default_nettype none
// Add, subtract and compare, purely combinational.
// Compare result is valid on cc_nxt_o regardless of the select; cc_we_o qualifies it.

module ieu_arith (
   input  ieu_pkg::word_t     operand_1_i,
   input  ieu_pkg::word_t     operand_2_i,
   input  ieu_pkg::arith_opc_t opc_i,
   input  logic               cmp_signed_i,
   output ieu_pkg::word_t     sum_o,
   output logic               cc_nxt_o,
   output logic               cc_we_o
);

   import ieu_pkg::*;

   logic [DATA_W:0] diff;   // Extra bit holds the carry out
   word_t add_res;
   logic unsigned_lt;
   logic signed_lt;
   logic sign_1;
   logic sign_2;

   // op1 - op2 as op1 + ~op2 + 1
   assign diff = {1'b0, operand_1_i} + {1'b0, ~operand_2_i} + 1'b1;
   assign add_res = operand_1_i + operand_2_i;

   assign sign_1 = operand_1_i[DATA_W-1];
   assign sign_2 = operand_2_i[DATA_W-1];

   // No carry out means a borrow, so op1 < op2
   assign unsigned_lt = ~diff[DATA_W];

   // Differing signs decide directly, else the sign of the difference
   assign signed_lt = (sign_1 != sign_2) ? sign_1 : diff[DATA_W-1];

   assign sum_o = opc_i[ARITH_ADD] ? add_res : diff[DATA_W-1:0];

   assign cc_nxt_o = cmp_signed_i ? signed_lt : unsigned_lt;
   assign cc_we_o = opc_i[ARITH_CMP];

endmodule

`default_nettype wire

//--- rtl/ieu_logic.sv
`timescale 1ns/1ns
`default_nettype none
// Bitwise operations and shifts. Shift amount is operand 2 [4:0].
// Output is zero when no select is set.

module ieu_logic (
   input  ieu_pkg::word_t      operand_1_i,
   input  ieu_pkg::word_t      operand_2_i,
   input  ieu_pkg::logic_opc_t opc_i,
   output ieu_pkg::word_t      logic_o
);

   import ieu_pkg::*;

   logic [4:0] shamt;
   word_t and_res;
   word_t or_res;
   word_t xor_res;
   word_t sll_res;
   word_t srl_res;
   word_t sra_res;

   assign shamt = operand_2_i[4:0];

   assign and_res = operand_1_i & operand_2_i;
   assign or_res = operand_1_i | operand_2_i;
   assign xor_res = operand_1_i ^ operand_2_i;
   assign sll_res = operand_1_i << shamt;
   assign srl_res = operand_1_i >> shamt;
   assign sra_res = $signed(operand_1_i) >>> shamt;   // Replicates the sign bit

   // One-hot AND-OR mux
   assign logic_o = ({DATA_W{opc_i[LOGIC_AND]}} & and_res) |
                    ({DATA_W{opc_i[LOGIC_OR]}} & or_res) |
                    ({DATA_W{opc_i[LOGIC_XOR]}} & xor_res) |
                    ({DATA_W{opc_i[LOGIC_SLL]}} & sll_res) |
                    ({DATA_W{opc_i[LOGIC_SRL]}} & srl_res) |
                    ({DATA_W{opc_i[LOGIC_SRA]}} & sra_res);

endmodule

`default_nettype wire

//--- rtl/ieu_lsu.sv
`timescale 1ns/1ns
`default_nettype none
// Load/store unit, one access in flight. Operands must stay stable until done_o.
// The bus returns the whole aligned word; stores get no response.

module ieu_lsu (
   input  logic              clk,
   input  logic              reset_i,
   input  logic              start_i,
   input  logic              load_i,
   input  logic              sign_ext_i,
   input  ieu_pkg::mem_size_t size_i,
   input  ieu_pkg::word_t    operand_1_i,
   input  ieu_pkg::word_t    operand_2_i,
   input  ieu_pkg::word_t    operand_3_i,
   output logic              dbus_req_valid_o,
   input  logic              dbus_req_ready_i,
   output ieu_pkg::word_t    dbus_addr_o,
   output logic              dbus_we_o,
   output ieu_pkg::word_t    dbus_wdata_o,
   output ieu_pkg::mem_size_t dbus_size_o,
   input  logic              dbus_rsp_valid_i,
   input  ieu_pkg::word_t    dbus_rdata_i,
   output logic              dbus_rsp_ready_o,
   output ieu_pkg::word_t    load_data_o,
   output logic              done_o
);

   import ieu_pkg::*;

   lsu_state_t state_q;
   lsu_state_t state_d;
   word_t addr;
   word_t store_data;
   word_t load_ext;
   logic [7:0] load_byte;
   logic [15:0] load_half;
   logic req_fire;
   logic rsp_fire;

   assign addr = operand_1_i + operand_2_i;

   assign req_fire = dbus_req_valid_o & dbus_req_ready_i;
   assign rsp_fire = dbus_rsp_valid_i & dbus_rsp_ready_o;

   // Replicate store data into every lane of its size
   always_comb begin
      case (size_i)
         SIZE_BYTE: store_data = {4{operand_3_i[7:0]}};
         SIZE_HALF: store_data = {2{operand_3_i[15:0]}};
         default:   store_data = operand_3_i;
      endcase
   end

   // Lane select by low address bits
   always_comb begin
      case (addr[1:0])
         2'd0:    load_byte = dbus_rdata_i[7:0];
         2'd1:    load_byte = dbus_rdata_i[15:8];
         2'd2:    load_byte = dbus_rdata_i[23:16];
         default: load_byte = dbus_rdata_i[31:24];
      endcase
      load_half = addr[1] ? dbus_rdata_i[31:16] : dbus_rdata_i[15:0];
      case (size_i)
         SIZE_BYTE: load_ext = {{(DATA_W-8){sign_ext_i & load_byte[7]}}, load_byte};
         SIZE_HALF: load_ext = {{(DATA_W-16){sign_ext_i & load_half[15]}}, load_half};
         default:   load_ext = dbus_rdata_i;
      endcase
   end

   always_comb begin
      state_d = state_q;
      case (state_q)
         LSU_IDLE: begin
            if (start_i) begin
               state_d = LSU_REQ;
            end
         end
         LSU_REQ: begin
            if (req_fire) begin
               state_d = load_i ? LSU_RSP : LSU_IDLE;   // Stores finish on acceptance
            end
         end
         LSU_RSP: begin
            if (dbus_rsp_valid_i) begin
               state_d = LSU_IDLE;
            end
         end
         default: state_d = LSU_IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset_i) begin
         state_q <= LSU_IDLE;
         done_o <= 1'b0;
      end else begin
         state_q <= state_d;
         done_o <= (req_fire & ~load_i) | rsp_fire;   // One-cycle pulse
      end
   end

   always_ff @(posedge clk) begin
      if (rsp_fire) begin
         load_data_o <= load_ext;
      end
   end

   assign dbus_req_valid_o = (state_q == LSU_REQ);
   assign dbus_rsp_ready_o = (state_q == LSU_RSP);
   assign dbus_addr_o = addr;
   assign dbus_we_o = ~load_i;
   assign dbus_wdata_o = store_data;
   assign dbus_size_o = size_i;

endmodule

`default_nettype wire

//--- rtl/ieu_branch.sv
`timescale 1ns/1ns
`default_nettype none
// Branch resolution for speculatively fetched jumps, combinational.
// jmprel_i and jmpfar_i are never set together.

module ieu_branch (
   input  logic           valid_i,
   input  logic           jmprel_i,
   input  logic           jmpfar_i,
   input  logic           bcc_i,        // Predicted condition
   input  logic           psr_cc_i,
   input  ieu_pkg::pc_t   spec_tgt_i,
   input  ieu_pkg::word_t operand_1_i,  // Far jump byte address
   output logic           flush_o,
   output ieu_pkg::pc_t   target_o,
   output logic           bpu_wb_o,
   output logic           bpu_hit_o
);

   import ieu_pkg::*;

   pc_t far_tgt;
   logic rel_miss;
   logic far_miss;

   assign far_tgt = operand_1_i[DATA_W-1:2];

   assign rel_miss = jmprel_i & (bcc_i != psr_cc_i);
   assign far_miss = jmpfar_i & (spec_tgt_i != far_tgt);

   assign flush_o = valid_i & (rel_miss | far_miss);

   // Redirect target of the jump being resolved
   assign target_o = ({PC_W{jmprel_i}} & spec_tgt_i) |
                     ({PC_W{jmpfar_i}} & far_tgt);

   assign bpu_wb_o = valid_i & (jmprel_i | jmpfar_i);
   assign bpu_hit_o = ~(rel_miss | far_miss);

endmodule

`default_nettype wire

//--- rtl/ieu_top.sv
`timescale 1ns/1ns
`default_nettype none
// Integer execution stage. Inputs must be held until in_ready_o while in_valid_i.
// Non-memory instructions commit in the cycle they are presented.

module ieu_top (
   input  logic                clk,
   input  logic                reset_i,
   input  logic                in_valid_i,
   output logic                in_ready_o,
   input  ieu_pkg::word_t      operand_1_i,
   input  ieu_pkg::word_t      operand_2_i,
   input  ieu_pkg::word_t      operand_3_i,
   input  ieu_pkg::arith_opc_t arith_opc_i,
   input  logic                cmp_signed_i,
   input  ieu_pkg::logic_opc_t logic_opc_i,
   input  logic                mem_load_i,
   input  logic                mem_store_i,
   input  logic                mem_sign_ext_i,
   input  ieu_pkg::mem_size_t  mem_size_i,
   input  logic                wb_regf_i,
   input  ieu_pkg::reg_addr_t  wb_reg_addr_i,
   input  logic                jmplink_i,
   input  ieu_pkg::pc_t        insn_pc_i,
   input  logic                specul_jmprel_i,
   input  logic                specul_jmpfar_i,
   input  logic                specul_bcc_i,
   input  ieu_pkg::pc_t        specul_tgt_i,
   input  logic                psr_cc_i,
   output logic                regf_we_o,
   output ieu_pkg::reg_addr_t  regf_addr_o,
   output ieu_pkg::word_t      regf_din_o,
   output logic                cc_we_o,
   output logic                cc_nxt_o,
   output logic                dbus_req_valid_o,
   input  logic                dbus_req_ready_i,
   output ieu_pkg::word_t      dbus_addr_o,
   output logic                dbus_we_o,
   output ieu_pkg::word_t      dbus_wdata_o,
   output ieu_pkg::mem_size_t  dbus_size_o,
   input  logic                dbus_rsp_valid_i,
   input  ieu_pkg::word_t      dbus_rdata_i,
   output logic                dbus_rsp_ready_o,
   output logic                flush_o,
   output ieu_pkg::pc_t        flush_tgt_o,
   output logic                bpu_wb_o,
   output logic                bpu_wb_jmprel_o,
   output logic                bpu_wb_hit_o,
   output ieu_pkg::pc_t        bpu_wb_pc_o
);

   import ieu_pkg::*;

   word_t sum;
   logic arith_cc_we;
   word_t logic_res;
   word_t load_data;
   logic lsu_done;
   logic is_mem;
   logic lsu_start;
   logic commit;
   logic sum_sel;
   pc_t link_pc;
   word_t link_addr;

   assign is_mem = mem_load_i | mem_store_i;
   assign lsu_start = in_valid_i & is_mem & ~lsu_done;   // No restart in the done cycle

   ieu_arith u_arith (
      .operand_1_i  (operand_1_i),
      .operand_2_i  (operand_2_i),
      .opc_i        (arith_opc_i),
      .cmp_signed_i (cmp_signed_i),
      .sum_o        (sum),
      .cc_nxt_o     (cc_nxt_o),
      .cc_we_o      (arith_cc_we)
   );

   ieu_logic u_logic (
      .operand_1_i (operand_1_i),
      .operand_2_i (operand_2_i),
      .opc_i       (logic_opc_i),
      .logic_o     (logic_res)
   );

   ieu_lsu u_lsu (
      .clk              (clk),
      .reset_i          (reset_i),
      .start_i          (lsu_start),
      .load_i           (mem_load_i),
      .sign_ext_i       (mem_sign_ext_i),
      .size_i           (mem_size_i),
      .operand_1_i      (operand_1_i),
      .operand_2_i      (operand_2_i),
      .operand_3_i      (operand_3_i),
      .dbus_req_valid_o (dbus_req_valid_o),
      .dbus_req_ready_i (dbus_req_ready_i),
      .dbus_addr_o      (dbus_addr_o),
      .dbus_we_o        (dbus_we_o),
      .dbus_wdata_o     (dbus_wdata_o),
      .dbus_size_o      (dbus_size_o),
      .dbus_rsp_valid_i (dbus_rsp_valid_i),
      .dbus_rdata_i     (dbus_rdata_i),
      .dbus_rsp_ready_o (dbus_rsp_ready_o),
      .load_data_o      (load_data),
      .done_o           (lsu_done)
   );

   ieu_branch u_branch (
      .valid_i     (in_valid_i),
      .jmprel_i    (specul_jmprel_i),
      .jmpfar_i    (specul_jmpfar_i),
      .bcc_i       (specul_bcc_i),
      .psr_cc_i    (psr_cc_i),
      .spec_tgt_i  (specul_tgt_i),
      .operand_1_i (operand_1_i),
      .flush_o     (flush_o),
      .target_o    (flush_tgt_o),
      .bpu_wb_o    (bpu_wb_o),
      .bpu_hit_o   (bpu_wb_hit_o)
   );

   // Byte address of the instruction after the jump
   assign link_pc = insn_pc_i + 1'b1;
   assign link_addr = {link_pc, 2'b00};

   // Memory ops commit on the LSU done pulse
   assign commit = in_valid_i & (is_mem ? lsu_done : 1'b1);

   assign sum_sel = arith_opc_i[ARITH_ADD] | arith_opc_i[ARITH_SUB];

   // logic_res is already zero without a logic select
   assign regf_din_o = ({DATA_W{sum_sel}} & sum) |
                       logic_res |
                       ({DATA_W{mem_load_i}} & load_data) |
                       ({DATA_W{jmplink_i}} & link_addr);

   assign regf_addr_o = wb_reg_addr_i;
   assign regf_we_o = commit & wb_regf_i;
   assign cc_we_o = commit & arith_cc_we;
   assign in_ready_o = commit;

   assign bpu_wb_jmprel_o = specul_jmprel_i;
   assign bpu_wb_pc_o = insn_pc_i;

endmodule

`default_nettype wire

//--- verification/tb_ieu_tasks.svh
// Directed test tasks included inside tb_ieu.
// Inputs change 2 ns after the rising edge and outputs are sampled at the falling edge.
`ifndef TB_IEU_TASKS_SVH
`define TB_IEU_TASKS_SVH

// Idle instruction with nothing selected
task automatic clear_insn();
   in_valid_i = 1'b0;
   operand_1_i = '0;
   operand_2_i = '0;
   operand_3_i = '0;
   arith_opc_i = '0;
   cmp_signed_i = 1'b0;
   logic_opc_i = '0;
   mem_load_i = 1'b0;
   mem_store_i = 1'b0;
   mem_sign_ext_i = 1'b0;
   mem_size_i = SIZE_WORD;
   wb_regf_i = 1'b0;
   wb_reg_addr_i = '0;
   jmplink_i = 1'b0;
   insn_pc_i = '0;
   specul_jmprel_i = 1'b0;
   specul_jmpfar_i = 1'b0;
   specul_bcc_i = 1'b0;
   specul_tgt_i = '0;
   psr_cc_i = 1'b0;
endtask

// Retire the current instruction at the next edge
task automatic end_insn();
   next_cycle();
   clear_insn();
endtask

task automatic wait_commit();
   int cycles;
   cycles = 0;
   @(negedge clk);
   while (in_ready_o !== 1'b1 && cycles < TIMEOUT_CYCLES) begin
      @(negedge clk);
      cycles++;
   end
   if (in_ready_o !== 1'b1) begin
      $display("Timeout at %0t: memory instruction never raised in_ready_o", $time);
      errors++;
      finish_run();
   end
endtask

task automatic check_logic_ops();
   word_t a;
   word_t b;
   word_t exp;
   int op;
   for (op = 0; op < LOGIC_OPW; op++) begin
      a = $random(seed);
      b = $random(seed);
      case (op)
         LOGIC_AND: exp = a & b;
         LOGIC_OR:  exp = a | b;
         LOGIC_XOR: exp = a ^ b;
         LOGIC_SLL: exp = a << b[4:0];
         LOGIC_SRL: exp = a >> b[4:0];
         default:   exp = (a >> b[4:0]) | (a[31] ? ~(32'hffffffff >> b[4:0]) : 32'h0);
      endcase
      operand_1_i = a;
      operand_2_i = b;
      logic_opc_i[op] = 1'b1;
      wb_regf_i = 1'b1;
      wb_reg_addr_i = reg_addr_t'(op + 1);
      in_valid_i = 1'b1;
      @(negedge clk);
      if (regf_din_o !== exp || regf_we_o !== 1'b1 || in_ready_o !== 1'b1) begin
         $display("MISMATCH at %0t: logic op %0d gave %h we %b, expected %h",
                  $time, op, regf_din_o, regf_we_o, exp);
         errors++;
      end
      end_insn();
   end
endtask

task automatic drive_arith(input int pos, input word_t a, input word_t b, input logic wb);
   arith_opc_i[pos] = 1'b1;
   operand_1_i = a;
   operand_2_i = b;
   wb_regf_i = wb;
   in_valid_i = 1'b1;
   @(negedge clk);
endtask

task automatic check_arith();
   word_t a;
   word_t b;
   word_t exp;
   logic exp_lt;
   int i;
   for (i = 0; i < 8; i++) begin
      a = $random(seed);
      b = (i < 2) ? a : $random(seed);   // Equal operands first
      exp_lt = i[0] ? ($signed(a) < $signed(b)) : (a < b);
      exp = a + b;
      drive_arith(ARITH_ADD, a, b, 1'b1);
      if (regf_din_o !== exp || regf_we_o !== 1'b1 || cc_we_o !== 1'b0) begin
         $display("MISMATCH at %0t: add gave %h, expected %h", $time, regf_din_o, exp);
         errors++;
      end
      end_insn();
      exp = a - b;
      drive_arith(ARITH_SUB, a, b, 1'b1);
      if (regf_din_o !== exp || regf_we_o !== 1'b1) begin
         $display("MISMATCH at %0t: sub gave %h, expected %h", $time, regf_din_o, exp);
         errors++;
      end
      end_insn();
      cmp_signed_i = i[0];
      drive_arith(ARITH_CMP, a, b, 1'b0);
      if (cc_we_o !== 1'b1 || cc_nxt_o !== exp_lt || regf_we_o !== 1'b0) begin
         $display("MISMATCH at %0t: cmp signed %0d of %h %h gave cc %b we %b, expected %b",
                  $time, i[0], a, b, cc_nxt_o, cc_we_o, exp_lt);
         errors++;
      end
      end_insn();
   end
endtask

task automatic check_stores();
   word_t rnd;
   word_t data;
   word_t mask;
   word_t exp_word;
   int sz;
   int off;
   int idx;
   int accepted;
   for (sz = 0; sz < 3; sz++) begin
      for (off = 0; off < 4; off++) begin
         if ((sz == 1 && off[0]) || (sz == 2 && off != 0)) continue;
         rnd = $random(seed);
         idx = rnd[5:0];
         data = $random(seed);
         mask = (sz == 0) ? 32'hff : (sz == 1) ? 32'hffff : 32'hffffffff;
         mask = mask << (8 * off);
         exp_word = (mem[idx] & ~mask) | ((data << (8 * off)) & mask);
         operand_1_i = idx * 4;
         operand_2_i = off;
         operand_3_i = data;
         mem_store_i = 1'b1;
         mem_size_i = (sz == 0) ? SIZE_BYTE : (sz == 1) ? SIZE_HALF : SIZE_WORD;
         in_valid_i = 1'b1;
         accepted = req_count;
         wait_commit();
         if (req_count != accepted + 1) begin
            $display("MISMATCH at %0t: in_ready_o rose before the store request was taken",
                     $time);
            errors++;
         end
         end_insn();
         if (mem[idx] !== exp_word) begin
            $display("MISMATCH at %0t: store size %0d off %0d left %h, expected %h",
                     $time, sz, off, mem[idx], exp_word);
            errors++;
         end
      end
   end
endtask

task automatic check_loads();
   word_t rnd;
   word_t exp;
   int sz;
   int off;
   int sext;
   int idx;
   for (sz = 0; sz < 3; sz++) begin
      for (off = 0; off < 4; off++) begin
         for (sext = 0; sext < 2; sext++) begin
            if ((sz == 1 && off[0]) || (sz == 2 && off != 0)) continue;
            rnd = $random(seed);
            idx = rnd[5:0];
            exp = mem[idx] >> (8 * off);
            if (sz == 0) begin
               exp = exp & 32'hff;
               if (sext == 1 && exp[7]) exp = exp | 32'hffffff00;
            end else if (sz == 1) begin
               exp = exp & 32'hffff;
               if (sext == 1 && exp[15]) exp = exp | 32'hffff0000;
            end
            operand_1_i = idx * 4 + off;   // Offset carried in operand 1 here
            operand_2_i = '0;
            mem_load_i = 1'b1;
            mem_sign_ext_i = sext[0];
            mem_size_i = (sz == 0) ? SIZE_BYTE : (sz == 1) ? SIZE_HALF : SIZE_WORD;
            wb_regf_i = 1'b1;
            wb_reg_addr_i = rnd[12:8];
            in_valid_i = 1'b1;
            wait_commit();
            if (regf_din_o !== exp || regf_we_o !== 1'b1 || regf_addr_o !== rnd[12:8]) begin
               $display("MISMATCH at %0t: load size %0d off %0d sext %0d gave %h to r%0d, %s %h",
                        $time, sz, off, sext, regf_din_o, regf_addr_o, "expected", exp);
               errors++;
            end
            end_insn();
         end
      end
   end
endtask

task automatic branch_case(input logic rel, input logic miss);
   word_t rnd;
   pc_t tgt;
   rnd = $random(seed);
   tgt = rnd[PC_W-1:0];
   rnd = $random(seed);
   specul_jmprel_i = rel;
   specul_jmpfar_i = ~rel;
   insn_pc_i = rnd[PC_W+1:2];
   if (rel) begin
      psr_cc_i = rnd[0];
      specul_bcc_i = rnd[0] ^ miss;
      specul_tgt_i = tgt;
      operand_1_i = rnd;
   end else begin
      operand_1_i = {tgt, rnd[1:0]};   // Byte address whose low bits are ignored
      specul_tgt_i = miss ? tgt + 1'b1 : tgt;
   end
   in_valid_i = 1'b1;
   @(negedge clk);
   if (flush_o !== miss || flush_tgt_o !== tgt || bpu_wb_o !== 1'b1 ||
       bpu_wb_hit_o !== ~miss || bpu_wb_jmprel_o !== rel || bpu_wb_pc_o !== insn_pc_i ||
       in_ready_o !== 1'b1) begin
      $display("MISMATCH at %0t: rel %b miss %b flush %b tgt %h pc %h hit %b, expected %h %h",
               $time, rel, miss, flush_o, flush_tgt_o, bpu_wb_pc_o, bpu_wb_hit_o,
               tgt, insn_pc_i);
      errors++;
   end
   end_insn();
endtask

task automatic check_branches();
   branch_case(1'b1, 1'b0);
   branch_case(1'b1, 1'b1);
   branch_case(1'b0, 1'b0);
   branch_case(1'b0, 1'b1);
endtask

task automatic check_jump_link();
   word_t rnd;
   word_t exp;
   int i;
   for (i = 0; i < 3; i++) begin
      rnd = $random(seed);
      insn_pc_i = (i == 2) ? '1 : rnd[PC_W-1:0];   // Last one wraps
      exp = ({2'b00, insn_pc_i} + 32'd1) * 32'd4;
      jmplink_i = 1'b1;
      wb_regf_i = 1'b1;
      wb_reg_addr_i = 5'd31;
      in_valid_i = 1'b1;
      @(negedge clk);
      if (regf_din_o !== exp || regf_we_o !== 1'b1) begin
         $display("MISMATCH at %0t: link address %h, expected %h", $time, regf_din_o, exp);
         errors++;
      end
      end_insn();
   end
endtask

`endif

//--- verification/tb_ieu.sv
`timescale 1ns/1ns
`default_nettype none
// Directed testbench for ieu_top with a 64-word data-bus memory model.
// Bus addresses wrap at 256 bytes. The model serves one access at a time.

module tb_ieu;

   import ieu_pkg::*;

   localparam int TIMEOUT_CYCLES = 40;

   // DUT inputs
   logic clk;
   logic reset_i;
   logic in_valid_i;
   word_t operand_1_i;
   word_t operand_2_i;
   word_t operand_3_i;
   arith_opc_t arith_opc_i;
   logic cmp_signed_i;
   logic_opc_t logic_opc_i;
   logic mem_load_i;
   logic mem_store_i;
   logic mem_sign_ext_i;
   mem_size_t mem_size_i;
   logic wb_regf_i;
   reg_addr_t wb_reg_addr_i;
   logic jmplink_i;
   pc_t insn_pc_i;
   logic specul_jmprel_i;
   logic specul_jmpfar_i;
   logic specul_bcc_i;
   pc_t specul_tgt_i;
   logic psr_cc_i;
   logic dbus_req_ready_i;
   logic dbus_rsp_valid_i;
   word_t dbus_rdata_i;

   // DUT outputs
   logic in_ready_o;
   logic regf_we_o;
   reg_addr_t regf_addr_o;
   word_t regf_din_o;
   logic cc_we_o;
   logic cc_nxt_o;
   logic dbus_req_valid_o;
   word_t dbus_addr_o;
   logic dbus_we_o;
   word_t dbus_wdata_o;
   mem_size_t dbus_size_o;
   logic dbus_rsp_ready_o;
   logic flush_o;
   pc_t flush_tgt_o;
   logic bpu_wb_o;
   logic bpu_wb_jmprel_o;
   logic bpu_wb_hit_o;
   pc_t bpu_wb_pc_o;

   word_t mem [0:63];
   integer seed = 32'h8d0cdd42;
   int errors = 0;
   int req_count = 0;   // Accepted bus requests

   ieu_top u_ieu_top (.*);

   initial clk = 1'b0;
   always #10 clk = ~clk;

   // Rising edge plus drive delay
   task automatic next_cycle();
      @(posedge clk);
      #2;
   endtask

   task automatic finish_run();
      $display("Checks finished with %0d errors", errors);
      if (errors == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   endtask

   `include "tb_ieu_tasks.svh"

   always @(posedge clk) begin
      if (dbus_req_valid_o === 1'b1 && dbus_req_ready_i === 1'b1) begin
         req_count <= req_count + 1;
      end
   end

   // Memory model with random accept and response delays
   initial begin : mem_model
      word_t addr;
      word_t wdata;
      word_t rnd;
      logic we;
      mem_size_t size;
      int i;
      for (i = 0; i < 64; i++) begin
         mem[i] = (i * 32'h9e3779b1) ^ 32'h80c04020;   // Mixes every address bit
      end
      dbus_req_ready_i = 1'b0;
      dbus_rsp_valid_i = 1'b0;
      dbus_rdata_i = '0;
      forever begin
         next_cycle();
         if (reset_i === 1'b0 && dbus_req_valid_o === 1'b1) begin
            rnd = $random(seed);
            repeat (rnd[1:0]) next_cycle();
            addr = dbus_addr_o;
            we = dbus_we_o;
            wdata = dbus_wdata_o;
            size = dbus_size_o;
            dbus_req_ready_i = 1'b1;
            next_cycle();   // Request taken on this edge
            dbus_req_ready_i = 1'b0;
            if (we) begin
               case (size)
                  SIZE_BYTE: mem[addr[7:2]][addr[1:0]*8 +: 8] = wdata[addr[1:0]*8 +: 8];
                  SIZE_HALF: mem[addr[7:2]][addr[1]*16 +: 16] = wdata[addr[1]*16 +: 16];
                  default:   mem[addr[7:2]] = wdata;
               endcase
            end else begin
               rnd = $random(seed);
               repeat (rnd[1:0]) next_cycle();
               dbus_rsp_valid_i = 1'b1;
               dbus_rdata_i = mem[addr[7:2]];   // Whole aligned word
               if (dbus_rsp_ready_o !== 1'b1) begin
                  $display("MISMATCH at %0t: load response offered with dbus_rsp_ready_o low",
                           $time);
                  errors++;
               end
               next_cycle();
               dbus_rsp_valid_i = 1'b0;
            end
         end
      end
   end

   initial begin
      clear_insn();
      reset_i = 1'b1;
      repeat (10) @(posedge clk);
      #2;
      reset_i = 1'b0;
      check_logic_ops();
      check_arith();
      check_stores();
      check_loads();
      check_branches();
      check_jump_link();
      finish_run();
   end

endmodule

`default_nettype wire

//--- files.f
+incdir+verification
rtl/ieu_pkg.sv
rtl/ieu_arith.sv
rtl/ieu_logic.sv
rtl/ieu_lsu.sv
rtl/ieu_branch.sv
rtl/ieu_top.sv
verification/tb_ieu.sv
